// ==== rtl/hsid_pkg.sv ====
`default_nettype none

package hsid_pkg;

  localparam int word_width       = 32;                    // Bus word, two bands per word
  localparam int data_width       = 16;                    // One unsigned band sample
  localparam int data_width_acc   = 48;                    // Lane accumulator width
  localparam int hsi_bands        = 16;                    // Samples per vector
  localparam int hsi_bands_addr   = $clog2(hsi_bands);     // Shift for the mean
  localparam int hsi_words        = hsi_bands / 2;         // Bus words per vector
  localparam int word_cnt_w       = $clog2(hsi_words);     // Word counter width
  localparam int hsi_library_size = 16;                    // Library vectors
  localparam int lib_addr_w       = $clog2(hsi_library_size);
  localparam int count_w          = 8;                     // Result counter, wraps
  localparam int adr_w            = 5;                     // Byte address on the bus

  // Register map, byte addresses
  localparam logic [adr_w-1:0] reg_ref      = 5'h00;  // Library index, restarts vector
  localparam logic [adr_w-1:0] reg_pix      = 5'h04;  // Pixel word
  localparam logic [adr_w-1:0] reg_lib      = 5'h08;  // Library word, issues an element
  localparam logic [adr_w-1:0] reg_clear    = 5'h0C;  // Clears the result side
  localparam logic [adr_w-1:0] reg_best     = 5'h10;  // Smallest MSE
  localparam logic [adr_w-1:0] reg_best_ref = 5'h14;  // Index, found, count
  localparam logic [adr_w-1:0] reg_last_mse = 5'h18;  // Latest MSE

  // Field positions inside BEST_REF
  localparam int best_ref_found_bit = 8;
  localparam int best_ref_count_lsb = 16;

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [adr_w-1:0]      adr;
    logic [word_width-1:0] dat;     // Write data
  } hsid_wb_req_t;

  typedef struct packed {
    logic                  first;   // Opens a new vector
    logic                  last;    // Closes the vector
    logic [lib_addr_w-1:0] ref_idx; // Library index of the vector
    logic [word_width-1:0] a;       // Pixel word
    logic [word_width-1:0] b;       // Library word
  } hsid_elem_t;

  typedef struct packed {
    logic [lib_addr_w-1:0] ref_idx;
    logic [word_width-1:0] value;
  } hsid_mse_t;

endpackage

`default_nettype wire

// ==== rtl/hsid_sq_df_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module hsid_sq_df_acc (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                data_in_valid,
  input  logic                                data_in_first,
  input  logic                                data_in_last,
  input  logic [hsid_pkg::lib_addr_w-1:0]     data_in_ref,
  input  logic [hsid_pkg::data_width-1:0]     data_in_a,
  input  logic [hsid_pkg::data_width-1:0]     data_in_b,
  output logic                                acc_valid,
  output logic [hsid_pkg::data_width_acc-1:0] acc_value,
  output logic                                acc_last,
  output logic [hsid_pkg::lib_addr_w-1:0]     acc_ref
);
  import hsid_pkg::*;

  logic                         diff_valid;
  logic                         diff_first;
  logic                         diff_last;
  logic [lib_addr_w-1:0]        diff_ref;
  logic signed [data_width:0]   diff_q;     // a - b, one extra bit for the sign
  logic signed [2*data_width+1:0] sq;       // Never negative
  logic [data_width_acc-1:0]    sq_ext;

  assign sq     = diff_q * diff_q;
  assign sq_ext = data_width_acc'(unsigned'(sq));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      diff_valid <= 1'b0;
      acc_valid  <= 1'b0;
    end else begin
      diff_valid <= data_in_valid;
      acc_valid  <= diff_valid;  // Two cycles from input to sum
    end
  end

  always_ff @(posedge clk) begin
    if (data_in_valid) begin  // Difference stage
      diff_q     <= $signed({1'b0, data_in_a}) - $signed({1'b0, data_in_b});
      diff_first <= data_in_first;
      diff_last  <= data_in_last;
      diff_ref   <= data_in_ref;
    end
    if (diff_valid) begin  // Square and accumulate stage
      acc_value <= diff_first ? sq_ext : acc_value + sq_ext;  // First element restarts the sum
      acc_last  <= diff_last;
      acc_ref   <= diff_ref;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/hsid_mse.sv ====
`timescale 1ns/1ps
`default_nettype none

module hsid_mse (
  input  logic                 clk,
  input  logic                 rst_n,
  input  hsid_pkg::hsid_elem_t elem,
  input  logic                 elem_valid,
  output hsid_pkg::hsid_mse_t  mse,
  output logic                 mse_valid
);
  import hsid_pkg::*;

  hsid_elem_t              elem_q;       // Input register
  logic                    elem_q_valid;

  // Lane results
  logic                      lane0_valid;
  logic                      lane0_last;
  logic [lib_addr_w-1:0]     lane0_ref;
  logic [data_width_acc-1:0] lane0_value;
  logic [data_width_acc-1:0] lane1_value;

  // Lane sum stage
  logic                      sum_valid;
  logic [data_width_acc:0]   sum_value;  // One bit wider than a lane
  logic [lib_addr_w-1:0]     sum_ref;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      elem_q_valid <= 1'b0;
      sum_valid    <= 1'b0;
      mse_valid    <= 1'b0;
    end else begin
      elem_q_valid <= elem_valid;
      sum_valid    <= lane0_valid && lane0_last;  // Lanes run in lockstep
      mse_valid    <= sum_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (elem_valid) begin
      elem_q <= elem;
    end
    if (lane0_valid && lane0_last) begin
      sum_value <= {1'b0, lane0_value} + {1'b0, lane1_value};
      sum_ref   <= lane0_ref;
    end
    if (sum_valid) begin
      mse.value   <= word_width'(sum_value >> hsi_bands_addr);  // Mean over all bands
      mse.ref_idx <= sum_ref;
    end
  end

  // Low halves of both words
  hsid_sq_df_acc lane0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_in_valid (elem_q_valid),
    .data_in_first (elem_q.first),
    .data_in_last  (elem_q.last),
    .data_in_ref   (elem_q.ref_idx),
    .data_in_a     (elem_q.a[data_width-1:0]),
    .data_in_b     (elem_q.b[data_width-1:0]),
    .acc_valid     (lane0_valid),
    .acc_value     (lane0_value),
    .acc_last      (lane0_last),
    .acc_ref       (lane0_ref)
  );

  // High halves, control outputs follow lane0 and stay open
  hsid_sq_df_acc lane1 (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_in_valid (elem_q_valid),
    .data_in_first (elem_q.first),
    .data_in_last  (elem_q.last),
    .data_in_ref   (elem_q.ref_idx),
    .data_in_a     (elem_q.a[word_width-1:data_width]),
    .data_in_b     (elem_q.b[word_width-1:data_width]),
    .acc_valid     (),
    .acc_value     (lane1_value),
    .acc_last      (),
    .acc_ref       ()
  );

endmodule

`default_nettype wire

// ==== rtl/hsid_best_match.sv ====
`timescale 1ns/1ps
`default_nettype none

module hsid_best_match (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            clear,
  input  hsid_pkg::hsid_mse_t             mse,
  input  logic                            mse_valid,
  output hsid_pkg::hsid_mse_t             best,
  output logic                            best_found,
  output logic [hsid_pkg::count_w-1:0]    result_count,
  output logic [hsid_pkg::word_width-1:0] last_mse
);
  import hsid_pkg::*;

  logic better;  // Result beats the stored best

  assign better = !best_found || (mse.value < best.value);  // Ties keep the earlier one

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      best         <= '0;
      best_found   <= 1'b0;
      result_count <= '0;
      last_mse     <= '0;
    end else if (clear) begin  // Wins over a result in the same cycle
      best         <= '0;
      best_found   <= 1'b0;
      result_count <= '0;
      last_mse     <= '0;
    end else if (mse_valid) begin
      result_count <= result_count + 1'b1;  // Wraps
      last_mse     <= mse.value;
      if (better) begin
        best       <= mse;
        best_found <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/hsid_wb_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module hsid_wb_slave (
  input  logic                            clk,
  input  logic                            rst_n,
  input  hsid_pkg::hsid_wb_req_t          wb_req,
  output logic [hsid_pkg::word_width-1:0] wb_dat_r,
  output logic                            wb_ack,
  output hsid_pkg::hsid_elem_t            elem,
  output logic                            elem_valid,
  output logic                            clear,
  input  hsid_pkg::hsid_mse_t             best,
  input  logic                            best_found,
  input  logic [hsid_pkg::count_w-1:0]    result_count,
  input  logic [hsid_pkg::word_width-1:0] last_mse
);
  import hsid_pkg::*;

  logic                  req_on;    // Master has a cycle open
  logic                  ack_hold;  // Acked, waiting for stb to drop
  logic                  wr_en;     // Write takes effect this cycle
  logic [lib_addr_w-1:0] ref_q;     // Library index of the vector in progress
  logic [word_width-1:0] pix_q;     // Pixel word paired with the next LIB write
  logic [word_cnt_w-1:0] word_cnt;  // Position inside the vector

  assign req_on = wb_req.cyc && wb_req.stb;
  assign wr_en  = wb_ack && wb_req.we;  // Request is held, so decode in the ack cycle

  // Single-cycle ack, one per strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack   <= 1'b0;
      ack_hold <= 1'b0;
    end else begin
      wb_ack   <= req_on && !wb_ack && !ack_hold;
      ack_hold <= req_on && (ack_hold || wb_ack);  // Released once stb drops
    end
  end

  // Word counter sets first and last of each element
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= '0;
    end else if (wr_en && wb_req.adr == reg_ref) begin
      word_cnt <= '0;  // New vector, anything half written is dropped
    end else if (elem_valid) begin
      if (word_cnt == word_cnt_w'(hsi_words - 1)) begin
        word_cnt <= '0;
      end else begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // Host data registers
  always_ff @(posedge clk) begin
    if (wr_en && wb_req.adr == reg_ref) begin
      ref_q <= wb_req.dat[lib_addr_w-1:0];
    end
    if (wr_en && wb_req.adr == reg_pix) begin
      pix_q <= wb_req.dat;
    end
  end

  // Element straight from the held write data
  always_comb begin
    elem.first   = (word_cnt == '0);
    elem.last    = (word_cnt == word_cnt_w'(hsi_words - 1));
    elem.ref_idx = ref_q;
    elem.a       = pix_q;
    elem.b       = wb_req.dat;
  end

  assign elem_valid = wr_en && (wb_req.adr == reg_lib);
  assign clear      = wr_en && (wb_req.adr == reg_clear);

  // Read mux, sampled by the master in the ack cycle
  always_comb begin
    wb_dat_r = '0;  // Write-only and unmapped addresses read 0
    case (wb_req.adr)
      reg_best: begin
        wb_dat_r = best.value;
      end
      reg_best_ref: begin
        wb_dat_r[lib_addr_w-1:0]                 = best.ref_idx;
        wb_dat_r[best_ref_found_bit]             = best_found;
        wb_dat_r[best_ref_count_lsb +: count_w]  = result_count;
      end
      reg_last_mse: begin
        wb_dat_r = last_mse;
      end
      default: begin
        wb_dat_r = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/hsid_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hsid_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  hsid_pkg::hsid_wb_req_t          wb_req,
  output logic [hsid_pkg::word_width-1:0] wb_dat_r,
  output logic                            wb_ack
);
  import hsid_pkg::*;

  hsid_elem_t            elem;          // Slave to MSE pipeline
  logic                  elem_valid;
  hsid_mse_t             mse;           // MSE pipeline to tracker
  logic                  mse_valid;
  logic                  clear;
  hsid_mse_t             best;          // Tracker back to the slave
  logic                  best_found;
  logic [count_w-1:0]    result_count;
  logic [word_width-1:0] last_mse;

  hsid_wb_slave u_slave (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_req       (wb_req),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .elem         (elem),
    .elem_valid   (elem_valid),
    .clear        (clear),
    .best         (best),
    .best_found   (best_found),
    .result_count (result_count),
    .last_mse     (last_mse)
  );

  hsid_mse u_mse (
    .clk        (clk),
    .rst_n      (rst_n),
    .elem       (elem),
    .elem_valid (elem_valid),
    .mse        (mse),
    .mse_valid  (mse_valid)
  );

  hsid_best_match u_best (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear        (clear),
    .mse          (mse),
    .mse_valid    (mse_valid),
    .best         (best),
    .best_found   (best_found),
    .result_count (result_count),
    .last_mse     (last_mse)
  );

endmodule

`default_nettype wire

// ==== tb/hsid_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module hsid_assert (
  input logic                   clk,
  input logic                   rst_n,
  input hsid_pkg::hsid_wb_req_t wb_req,
  input logic                   wb_ack,
  input logic                   elem_valid,
  input logic                   mse_valid
);

  // Ack answers an open request only
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> (wb_req.cyc && wb_req.stb))
    else $error("wb_ack high without cyc and stb");

  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else $error("wb_ack held for two cycles");  // Single-cycle handshake

  // Every result traces back to an element five cycles earlier
  mse_after_elem: assert property (@(posedge clk) disable iff (!rst_n)
    mse_valid |-> $past(elem_valid, 5))
    else $error("mse_valid without an element five cycles before");

  mse_single: assert property (@(posedge clk) disable iff (!rst_n)
    mse_valid |=> !mse_valid)
    else $error("mse_valid high in two adjacent cycles");  // One result per vector

endmodule

bind hsid_top hsid_assert u_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .wb_req     (wb_req),
  .wb_ack     (wb_ack),
  .elem_valid (elem_valid),
  .mse_valid  (mse_valid)
);

`default_nettype wire

// ==== tb/tb_hsid_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hsid_top;
  import hsid_pkg::*;

  localparam int clk_period      = 20;
  localparam int ack_timeout     = 16;  // Cycles a transfer may wait for ack
  localparam int result_latency  = 6;   // LAST ack to readable result
  localparam int num_tests       = 6;
  localparam int watchdog_cycles = num_tests * 40 * 20 * 3 + 1000;

  logic                  clk;
  logic                  rst_n;
  hsid_wb_req_t          wb_req;
  logic [word_width-1:0] wb_dat_r;
  logic                  wb_ack;

  logic [data_width-1:0] pix_band [hsi_bands];                    // Pixel spectrum
  logic [data_width-1:0] lib_band [hsi_library_size][hsi_bands];  // Library spectra

  hsid_mse_t             model_best;   // Reference tracker
  logic                  model_found;
  logic [count_w-1:0]    model_count;
  logic [word_width-1:0] model_last;

  int                    error_count;
  int                    check_count;
  int                    test_errors;  // Errors before the current test
  int                    idx;
  logic [word_width-1:0] rd;

  hsid_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_req   (wb_req),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin  // Watchdog
    #(watchdog_cycles * clk_period);
    $display("Run stopped by the watchdog after %0d cycles", watchdog_cycles);
    $display("Checks failed");
    $finish;
  end

  // One Wishbone classic transfer with the request held through the ack cycle
  task automatic bus_cycle(input logic we, input logic [adr_w-1:0] adr,
                           input logic [word_width-1:0] wdat,
                           output logic [word_width-1:0] rdat);
    int waited;
    waited = 0;
    rdat   = '0;
    @(posedge clk);
    #1;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!wb_ack && waited < ack_timeout);
    if (wb_ack) begin
      rdat = wb_dat_r;  // Valid in the ack cycle
    end else begin
      error_count++;
      $display("No ack from address %h within %0d cycles", adr, ack_timeout);
    end
    @(posedge clk);
    #1;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic wb_write(input logic [adr_w-1:0] adr, input logic [word_width-1:0] dat);
    logic [word_width-1:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [adr_w-1:0] adr, output logic [word_width-1:0] dat);
    bus_cycle(1'b0, adr, '0, dat);
  endtask

  task automatic check_word(input string name, input logic [word_width-1:0] got,
                            input logic [word_width-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_mse(input string name, input hsid_mse_t got, input hsid_mse_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error t=%0t %s: got ref %0d value %h expected ref %0d value %h",
               $time, name, got.ref_idx, got.value, exp.ref_idx, exp.value);
    end
  endtask

  // Mean of squared band differences in 64-bit arithmetic
  function automatic logic [word_width-1:0] model_mse(input int lib_idx);
    longint sum;
    longint d;
    sum = 0;
    for (int i = 0; i < hsi_bands; i++) begin
      d   = longint'(pix_band[i]) - longint'(lib_band[lib_idx][i]);
      sum = sum + d * d;
    end
    return word_width'(sum / hsi_bands);
  endfunction

  function automatic logic [word_width-1:0] best_ref_word();
    logic [word_width-1:0] w;
    w                   = '0;
    w[lib_addr_w-1:0]   = model_best.ref_idx;  // Bits 3:0
    w[8]                = model_found;
    w[23:16]            = model_count;
    return w;
  endfunction

  task automatic model_clear();
    model_best  = '0;
    model_found = 1'b0;
    model_count = '0;
    model_last  = '0;
  endtask

  task automatic model_result(input hsid_mse_t r);
    if (!model_found || r.value < model_best.value) begin  // Strictly less so earlier wins a tie
      model_best  = r;
      model_found = 1'b1;
    end
    model_count = model_count + 1'b1;
    model_last  = r.value;
  endtask

  task automatic randomize_pixel();
    for (int i = 0; i < hsi_bands; i++) begin
      pix_band[i] = data_width'($urandom);
    end
  endtask

  task automatic randomize_library(input int lib_idx);
    for (int i = 0; i < hsi_bands; i++) begin
      lib_band[lib_idx][i] = data_width'($urandom);
    end
  endtask

  // REF write then a PIX and LIB pair per word
  // Fewer than hsi_words leaves the vector open
  task automatic send_vector(input int lib_idx, input int nwords);
    hsid_mse_t r;
    wb_write(reg_ref, word_width'(lib_idx));
    for (int w = 0; w < nwords; w++) begin
      wb_write(reg_pix, {pix_band[2*w+1], pix_band[2*w]});  // Lane 1 in the high half
      wb_write(reg_lib, {lib_band[lib_idx][2*w+1], lib_band[lib_idx][2*w]});
    end
    if (nwords == hsi_words) begin
      r.ref_idx = lib_addr_w'(lib_idx);
      r.value   = model_mse(lib_idx);
      model_result(r);
    end
  endtask

  task automatic sweep_library();
    for (int i = 0; i < hsi_library_size; i++) begin
      send_vector(i, hsi_words);
    end
    repeat (result_latency) @(posedge clk);
  endtask

  task automatic check_best();
    hsid_mse_t got;
    logic [word_width-1:0] w;
    wb_read(reg_best, w);
    got.value = w;
    wb_read(reg_best_ref, w);
    got.ref_idx = w[lib_addr_w-1:0];
    check_mse("best", got, model_best);
    check_word("BEST_REF", w, best_ref_word());
  endtask

  task automatic end_test(input int num, input string what);
    if (error_count == test_errors) begin
      $display("test %0d %s: ok", num, what);
    end else begin
      $display("test %0d %s: %0d errors", num, what, error_count - test_errors);
    end
    test_errors = error_count;
  endtask

  initial begin
    void'($urandom(32'ha2d7));  // Fixed seed
    wb_req      = '0;
    rst_n       = 1'b0;
    error_count = 0;
    check_count = 0;
    test_errors = 0;
    model_clear();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    wb_read(reg_best, rd);
    check_word("BEST", rd, '0);
    wb_read(reg_best_ref, rd);
    check_word("BEST_REF", rd, '0);
    wb_read(reg_last_mse, rd);
    check_word("LAST_MSE", rd, '0);
    wb_write(5'h1C, 32'hdead_beef);  // Unmapped address ignores the write
    wb_read(5'h1C, rd);
    check_word("unmapped 0x1C", rd, '0);
    end_test(1, "reset values");

    randomize_pixel();
    idx = int'($urandom_range(hsi_library_size - 1));
    randomize_library(idx);
    send_vector(idx, hsi_words);
    repeat (result_latency) @(posedge clk);
    wb_read(reg_last_mse, rd);
    check_word("LAST_MSE", rd, model_last);
    wb_read(reg_best_ref, rd);
    check_word("BEST_REF", rd, best_ref_word());
    end_test(2, "single vector");

    wb_write(reg_clear, '0);
    model_clear();
    randomize_pixel();
    for (int i = 0; i < hsi_library_size; i++) begin
      randomize_library(i);
    end
    for (int i = 0; i < hsi_bands; i++) begin
      lib_band[5][i]  = pix_band[i] ^ 16'h0001;  // MSE of 1
      lib_band[12][i] = lib_band[5][i];          // Same MSE as index 5 which must stay best
    end
    sweep_library();
    check_best();
    end_test(3, "library sweep with tie");

    for (int i = 0; i < hsi_bands; i++) begin
      pix_band[i]    = 16'hFFFF;
      lib_band[0][i] = 16'h0000;
    end
    send_vector(0, hsi_words);
    repeat (result_latency) @(posedge clk);
    wb_read(reg_last_mse, rd);
    check_word("LAST_MSE max", rd, 32'(65535 * 65535));  // 32-bit upper bound without truncation
    randomize_pixel();
    for (int i = 0; i < hsi_bands; i++) begin
      lib_band[7][i] = pix_band[i];
    end
    send_vector(7, hsi_words);
    repeat (result_latency) @(posedge clk);
    wb_read(reg_last_mse, rd);
    check_word("LAST_MSE exact", rd, '0);
    check_best();
    end_test(4, "exact match and upper bound");

    randomize_pixel();
    randomize_library(9);
    randomize_library(10);
    send_vector(9, 5);  // Abandoned by the next REF write
    send_vector(9, 3);  // Would reach the last word if REF did not restart the count
    repeat (result_latency) @(posedge clk);
    wb_read(reg_best_ref, rd);
    check_word("BEST_REF after abandon", rd, best_ref_word());
    send_vector(10, hsi_words);
    repeat (result_latency) @(posedge clk);
    wb_read(reg_last_mse, rd);
    check_word("LAST_MSE", rd, model_last);
    check_best();
    end_test(5, "abandoned vector");

    wb_write(reg_clear, '0);
    model_clear();
    wb_read(reg_best, rd);
    check_word("BEST cleared", rd, '0);
    wb_read(reg_best_ref, rd);
    check_word("BEST_REF cleared", rd, '0);
    wb_read(reg_last_mse, rd);
    check_word("LAST_MSE cleared", rd, '0);
    randomize_pixel();
    for (int i = 0; i < hsi_library_size; i++) begin
      randomize_library(i);
    end
    sweep_library();
    check_best();
    end_test(6, "clear and new sweep");

    $display("%0d tests, %0d checks, %0d errors", num_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/hsid_pkg.sv
rtl/hsid_sq_df_acc.sv
rtl/hsid_mse.sv
rtl/hsid_best_match.sv
rtl/hsid_wb_slave.sv
rtl/hsid_top.sv
tb/hsid_assert.sv
tb/tb_hsid_top.sv

// ==== Makefile ====
TOP := tb_hsid_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
